// File: source/spi_cfg_pkg.sv
// shared types, address map and instruction codes for the serial config port
// import with spi_cfg_pkg::* in each module header
`default_nettype none

package spi_cfg_pkg;

    localparam int BYTE_BITS = 8;

    typedef logic [BYTE_BITS-1:0] reg_byte_t;  // register data byte
    typedef logic [BYTE_BITS-1:0] reg_addr_t;  // register address
    typedef logic [2:0]           sel_idx_t;   // byte index inside an analog register

    // digital register map
    localparam reg_addr_t ADDR_TRIG_MASK   = 8'd1;
    localparam reg_addr_t ADDR_INSTRUCTION = 8'd2;
    localparam reg_addr_t ADDR_MODE        = 8'd3;
    localparam reg_addr_t ADDR_PLL_LOCKED  = 8'd60;  // read only
    localparam reg_addr_t ADDR_DISC_POL    = 8'd61;
    localparam reg_addr_t ADDR_VCO_CTRL    = 8'd62;
    localparam reg_addr_t ADDR_PLL_DIV     = 8'd63;
    localparam reg_addr_t ADDR_SLOW_MODE   = 8'd64;
    localparam reg_addr_t ADDR_TRIG_DELAY  = 8'd65;

    // analog window, 8 registers of 7 bytes each
    localparam reg_addr_t ADDR_ANALOG_FIRST = 8'd4;
    localparam reg_addr_t ADDR_ANALOG_LAST  = 8'd59;
    localparam int        ANALOG_BYTES      = 7;
    localparam int        ANALOG_REGS       = 8;
    localparam sel_idx_t  SELECT_IDLE       = 3'd7;  // nothing selected

    // instruction codes
    localparam reg_byte_t INST_RESET   = 8'd1;
    localparam reg_byte_t INST_READOUT = 8'd2;
    localparam reg_byte_t INST_START   = 8'd3;

    // one command per received frame
    typedef struct packed {
        logic      wr;    // single cycle
        logic      rd;    // single cycle
        reg_addr_t addr;
        reg_byte_t data;  // only meaningful with wr
    } frame_cmd_t;

    // held configuration outputs
    typedef struct packed {
        reg_byte_t trig_mask;
        reg_byte_t mode;
        reg_byte_t disc_polarity;
        reg_byte_t vco_control;
        reg_byte_t pll_div_ratio;
        reg_byte_t slow_mode;
        reg_byte_t trig_delay;
    } cfg_bank_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_RW,
        RX_ADDR,
        RX_DATA,
        RX_READ_WAIT
    } rx_state_t;

endpackage

`default_nettype wire

// File: source/spi_frame_rx.sv
// frame receiver for the serial config port
// waits for a start bit, takes r/w, address and write data MSB first,
// then issues a single wr or rd command on cmd
`default_nettype none
`timescale 1ns/1ps

module spi_frame_rx import spi_cfg_pkg::*; (
    input  logic       sclk,
    input  logic       rstn,
    input  logic       serial_in,
    output frame_cmd_t cmd
);

    rx_state_t state;
    logic [2:0] bit_cnt;   // bit position within the current byte
    logic       rw_q;      // 1 for a read frame
    reg_byte_t  shift_q;   // last bits seen on serial_in
    reg_byte_t  shift_next;

    // byte as it will be once the current bit is in
    assign shift_next = {shift_q[BYTE_BITS-2:0], serial_in};

    // free running input shifter, the FSM picks the byte out at the right time
    always_ff @(posedge sclk) begin
        shift_q <= shift_next;
    end

    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            state   <= RX_IDLE;
            bit_cnt <= '0;
            rw_q    <= 1'b0;
            cmd     <= '0;
        end else begin
            cmd.wr <= 1'b0;  // commands only last one cycle
            cmd.rd <= 1'b0;

            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    if (serial_in) begin  // start bit
                        state <= RX_RW;
                    end
                end

                RX_RW: begin
                    rw_q  <= serial_in;
                    state <= RX_ADDR;
                end

                RX_ADDR: begin
                    bit_cnt <= bit_cnt + 3'd1;  // wraps back to 0 after the byte
                    if (bit_cnt == 3'(BYTE_BITS - 1)) begin
                        cmd.addr <= shift_next;
                        if (rw_q) begin
                            cmd.rd <= 1'b1;
                            state  <= RX_READ_WAIT;
                        end else begin
                            state <= RX_DATA;
                        end
                    end
                end

                RX_DATA: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'(BYTE_BITS - 1)) begin
                        cmd.wr   <= 1'b1;
                        cmd.data <= shift_next;
                        state    <= RX_IDLE;
                    end
                end

                RX_READ_WAIT: begin
                    // line ignored while the read byte goes out
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'(BYTE_BITS - 1)) begin
                        state <= RX_IDLE;
                    end
                end

                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/config_regs.sv
// digital configuration register bank
// takes write commands by address, decodes the instruction register,
// and hands the addressed byte to the readout on a read command
`default_nettype none
`timescale 1ns/1ps

module config_regs import spi_cfg_pkg::*; (
    input  logic       sclk,
    input  logic       rstn,
    input  frame_cmd_t cmd,
    input  reg_byte_t  pll_locked,
    output cfg_bank_t  cfg,
    output logic       clk_enable,
    output logic       inst_rst,
    output logic       inst_readout,
    output logic       inst_start,
    output logic       rd_load,
    output reg_byte_t  rd_data
);

    reg_byte_t instruction;
    reg_byte_t rd_mux;
    logic      inst_wr;

    assign inst_wr = cmd.wr && (cmd.addr == ADDR_INSTRUCTION);

    // held enable while the start instruction sits in the register
    assign clk_enable = (instruction == INST_START);

    // register writes, unmapped addresses fall through
    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            cfg         <= '0;
            instruction <= '0;
        end else if (cmd.wr) begin
            case (cmd.addr)
                ADDR_TRIG_MASK:   cfg.trig_mask     <= cmd.data;
                ADDR_INSTRUCTION: instruction       <= cmd.data;
                ADDR_MODE:        cfg.mode          <= cmd.data;
                ADDR_DISC_POL:    cfg.disc_polarity <= cmd.data;
                ADDR_VCO_CTRL:    cfg.vco_control   <= cmd.data;
                ADDR_PLL_DIV:     cfg.pll_div_ratio <= cmd.data;
                ADDR_SLOW_MODE:   cfg.slow_mode     <= cmd.data;
                ADDR_TRIG_DELAY:  cfg.trig_delay    <= cmd.data;
                default: ;
            endcase
        end
    end

    // pulses line up with the instruction register update
    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            inst_rst     <= 1'b0;
            inst_readout <= 1'b0;
            inst_start   <= 1'b0;
        end else begin
            inst_rst     <= inst_wr && (cmd.data == INST_RESET);
            inst_readout <= inst_wr && (cmd.data == INST_READOUT);
            inst_start   <= inst_wr && (cmd.data == INST_START);
        end
    end

    // read data select
    always_comb begin
        case (cmd.addr)
            ADDR_TRIG_MASK:   rd_mux = cfg.trig_mask;
            ADDR_INSTRUCTION: rd_mux = instruction;
            ADDR_MODE:        rd_mux = cfg.mode;
            ADDR_PLL_LOCKED:  rd_mux = pll_locked;  // sampled at the load edge
            ADDR_DISC_POL:    rd_mux = cfg.disc_polarity;
            ADDR_VCO_CTRL:    rd_mux = cfg.vco_control;
            ADDR_PLL_DIV:     rd_mux = cfg.pll_div_ratio;
            ADDR_SLOW_MODE:   rd_mux = cfg.slow_mode;
            ADDR_TRIG_DELAY:  rd_mux = cfg.trig_delay;
            default:          rd_mux = '0;
        endcase
    end

    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            rd_load <= 1'b0;
        end else begin
            rd_load <= cmd.rd;
        end
    end

    always_ff @(posedge sclk) begin
        if (cmd.rd) begin
            rd_data <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: source/reg_readout.sv
// serializer for register reads
// a byte loaded with rd_load goes out on serial_out MSB first over 8 cycles,
// the line sits at 0 otherwise
`default_nettype none
`timescale 1ns/1ps

module reg_readout import spi_cfg_pkg::*; (
    input  logic      sclk,
    input  logic      rstn,
    input  logic      rd_load,
    input  reg_byte_t rd_data,
    output logic      serial_out
);

    reg_byte_t  shift_q;    // bits still to send, next one at the top
    logic [2:0] bits_left;

    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            serial_out <= 1'b0;
            bits_left  <= '0;
        end else if (rd_load) begin
            serial_out <= rd_data[BYTE_BITS-1];  // MSB goes straight out
            bits_left  <= 3'(BYTE_BITS - 1);
        end else if (bits_left != '0) begin
            serial_out <= shift_q[BYTE_BITS-1];
            bits_left  <= bits_left - 3'd1;
        end else begin
            serial_out <= 1'b0;  // idle low
        end
    end

    always_ff @(posedge sclk) begin
        if (rd_load) begin
            shift_q <= {rd_data[BYTE_BITS-2:0], 1'b0};
        end else begin
            shift_q <= {shift_q[BYTE_BITS-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: source/analog_load_ctrl.sv
// load control for the analog configuration registers
// a write into the analog window strobes one load_cnt_ser bit and
// holds the byte index and data for the analog side
`default_nettype none
`timescale 1ns/1ps

module analog_load_ctrl import spi_cfg_pkg::*; (
    input  logic       sclk,
    input  logic       rstn,
    input  frame_cmd_t cmd,
    output reg_byte_t  load_cnt_ser,
    output sel_idx_t   select_reg,
    output reg_byte_t  analog_data
);

    logic                           analog_wr;
    reg_addr_t                      offset;   // address relative to first analog byte
    logic [$clog2(ANALOG_REGS)-1:0] reg_num;
    sel_idx_t                       byte_idx;

    assign analog_wr = cmd.wr
                       && (cmd.addr >= ADDR_ANALOG_FIRST)
                       && (cmd.addr <= ADDR_ANALOG_LAST);

    // split into register number and byte within it
    assign offset   = cmd.addr - ADDR_ANALOG_FIRST;
    assign reg_num  = ($clog2(ANALOG_REGS))'(offset / ANALOG_BYTES);
    assign byte_idx = sel_idx_t'(offset % ANALOG_BYTES);

    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            load_cnt_ser <= '0;
            select_reg   <= SELECT_IDLE;
            analog_data  <= '0;
        end else begin
            load_cnt_ser <= '0;  // strobe is one cycle only
            if (analog_wr) begin
                load_cnt_ser[reg_num] <= 1'b1;
                select_reg            <= byte_idx;   // held until next analog write
                analog_data           <= cmd.data;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/spi_periph.sv
// top of the serial configuration port
// frame receiver feeds the register bank and the analog load control,
// the register bank feeds the readout serializer
`default_nettype none
`timescale 1ns/1ps

module spi_periph import spi_cfg_pkg::*; (
    input  logic      sclk,
    input  logic      rstn,
    input  logic      serial_in,
    input  reg_byte_t pll_locked,
    output cfg_bank_t cfg,
    output logic      clk_enable,
    output logic      inst_rst,
    output logic      inst_readout,
    output logic      inst_start,
    output logic      serial_out,
    output reg_byte_t load_cnt_ser,
    output sel_idx_t  select_reg,
    output reg_byte_t analog_data
);

    frame_cmd_t cmd;      // one command per frame
    logic       rd_load;
    reg_byte_t  rd_data;  // valid with rd_load

    spi_frame_rx u_frame_rx (
        .sclk      (sclk),
        .rstn      (rstn),
        .serial_in (serial_in),
        .cmd       (cmd)
    );

    config_regs u_config_regs (
        .sclk         (sclk),
        .rstn         (rstn),
        .cmd          (cmd),
        .pll_locked   (pll_locked),
        .cfg          (cfg),
        .clk_enable   (clk_enable),
        .inst_rst     (inst_rst),
        .inst_readout (inst_readout),
        .inst_start   (inst_start),
        .rd_load      (rd_load),
        .rd_data      (rd_data)
    );

    // read byte back to the host
    reg_readout u_reg_readout (
        .sclk       (sclk),
        .rstn       (rstn),
        .rd_load    (rd_load),
        .rd_data    (rd_data),
        .serial_out (serial_out)
    );

    // analog register strobes
    analog_load_ctrl u_analog_load_ctrl (
        .sclk         (sclk),
        .rstn         (rstn),
        .cmd          (cmd),
        .load_cnt_ser (load_cnt_ser),
        .select_reg   (select_reg),
        .analog_data  (analog_data)
    );

endmodule

`default_nettype wire

// File: test/tb_spi_periph.sv
// random-frame testbench for the serial configuration port
// sends read and write frames on serial_in and compares every output
// with a reference model once per cycle
`default_nettype none
`timescale 1ns/1ps

module tb_spi_periph import spi_cfg_pkg::*; ();

    localparam int NUM_FRAMES    = 300;
    localparam int WRITE_TIMEOUT = 8;   // cycles allowed for a write strobe

    logic      sclk;
    logic      rstn;
    logic      serial_in;
    reg_byte_t pll_locked;
    cfg_bank_t cfg;
    logic      clk_enable;
    logic      inst_rst;
    logic      inst_readout;
    logic      inst_start;
    logic      serial_out;
    reg_byte_t load_cnt_ser;
    sel_idx_t  select_reg;
    reg_byte_t analog_data;

    // reference model
    cfg_bank_t   exp_cfg;
    reg_byte_t   exp_inst;
    sel_idx_t    exp_sel;
    reg_byte_t   exp_adata;

    logic [31:0] lfsr;
    int          mismatches;
    int          timeouts;

    spi_periph UUT (
        .sclk         (sclk),
        .rstn         (rstn),
        .serial_in    (serial_in),
        .pll_locked   (pll_locked),
        .cfg          (cfg),
        .clk_enable   (clk_enable),
        .inst_rst     (inst_rst),
        .inst_readout (inst_readout),
        .inst_start   (inst_start),
        .serial_out   (serial_out),
        .load_cnt_ser (load_cnt_ser),
        .select_reg   (select_reg),
        .analog_data  (analog_data)
    );

    always #20 sclk = ~sclk;  // 40 ns period

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic reg_addr_t pick_address();
        reg_addr_t  mapped [9] = '{ADDR_TRIG_MASK, ADDR_INSTRUCTION, ADDR_MODE,
                                   ADDR_PLL_LOCKED, ADDR_DISC_POL, ADDR_VCO_CTRL,
                                   ADDR_PLL_DIV, ADDR_SLOW_MODE, ADDR_TRIG_DELAY};
        logic [1:0] kind;
        reg_addr_t  a;
        kind = rand_bits(2);
        case (kind)
            2'd0: a = mapped[rand_bits(4) % 9];
            2'd1: a = 8'd4 + rand_bits(6) % 56;   // analog window
            2'd2: begin
                a = rand_bits(8) % 191;
                if (a != 0) begin
                    a = a + 8'd65;                // 0 or 66..255
                end
            end
            default: a = ADDR_INSTRUCTION;       // extra weight on instructions
        endcase
        return a;
    endfunction

    function automatic reg_byte_t model_read(input reg_addr_t addr);
        case (addr)
            ADDR_TRIG_MASK:   return exp_cfg.trig_mask;
            ADDR_INSTRUCTION: return exp_inst;
            ADDR_MODE:        return exp_cfg.mode;
            ADDR_PLL_LOCKED:  return pll_locked;
            ADDR_DISC_POL:    return exp_cfg.disc_polarity;
            ADDR_VCO_CTRL:    return exp_cfg.vco_control;
            ADDR_PLL_DIV:     return exp_cfg.pll_div_ratio;
            ADDR_SLOW_MODE:   return exp_cfg.slow_mode;
            ADDR_TRIG_DELAY:  return exp_cfg.trig_delay;
            default:          return 8'h00;
        endcase
    endfunction

    task automatic apply_write(input reg_addr_t addr, input reg_byte_t data);
        case (addr)
            ADDR_TRIG_MASK:   exp_cfg.trig_mask     = data;
            ADDR_INSTRUCTION: exp_inst              = data;
            ADDR_MODE:        exp_cfg.mode          = data;
            ADDR_DISC_POL:    exp_cfg.disc_polarity = data;
            ADDR_VCO_CTRL:    exp_cfg.vco_control   = data;
            ADDR_PLL_DIV:     exp_cfg.pll_div_ratio = data;
            ADDR_SLOW_MODE:   exp_cfg.slow_mode     = data;
            ADDR_TRIG_DELAY:  exp_cfg.trig_delay    = data;
            default: ;
        endcase
        if (addr >= 8'd4 && addr <= 8'd59) begin
            exp_sel   = sel_idx_t'((addr - 8'd4) % 7);
            exp_adata = data;
        end
    endtask

    task automatic step();
        @(posedge sclk);
        #2;  // outputs settled, safe to drive
    endtask

    task automatic check_val(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
        assert (act_val === exp_val) else begin
            $display("[FAIL] %s expected %0h got %0h at %0t", name, exp_val, act_val, $time);
            mismatches++;
        end
    endtask

    // exp_pulse is {inst_rst, inst_readout, inst_start}
    task automatic check_state(input logic [2:0] exp_pulse, input reg_byte_t exp_load,
                               input logic exp_serial);
        check_val("cfg", exp_cfg, cfg);
        check_val("clk_enable", exp_inst == 8'd3, clk_enable);
        check_val("inst_rst", exp_pulse[2], inst_rst);
        check_val("inst_readout", exp_pulse[1], inst_readout);
        check_val("inst_start", exp_pulse[0], inst_start);
        check_val("load_cnt_ser", exp_load, load_cnt_ser);
        check_val("select_reg", exp_sel, select_reg);
        check_val("analog_data", exp_adata, analog_data);
        check_val("serial_out", exp_serial, serial_out);
    endtask

    task automatic send_bit(input logic b);
        serial_in = b;
        step();
        check_state(3'b000, 8'h00, 1'b0);  // nothing moves mid frame
    endtask

    task automatic send_frame(input logic rd, input reg_addr_t addr, input reg_byte_t data);
        int i;
        send_bit(1'b1);  // start
        send_bit(rd);
        for (i = 7; i >= 0; i--) begin
            send_bit(addr[i]);
        end
        if (!rd) begin
            for (i = 7; i >= 0; i--) begin
                send_bit(data[i]);
            end
        end
        serial_in = 1'b0;
    endtask

    task automatic finish_write(input reg_addr_t addr, input reg_byte_t data);
        logic [2:0] exp_pulse;
        reg_byte_t  exp_load;
        logic       want_strobe;
        int         cyc;
        exp_pulse = 3'b000;
        exp_load  = 8'h00;
        if (addr == ADDR_INSTRUCTION && data >= 8'd1 && data <= 8'd3) begin
            exp_pulse = 3'b100 >> (data - 8'd1);
        end
        if (addr >= 8'd4 && addr <= 8'd59) begin
            exp_load = 8'h01 << ((addr - 8'd4) / 7);
        end
        want_strobe = (exp_pulse != 3'b000) || (exp_load != 8'h00);

        // registers and strobes update one cycle after cmd.wr
        for (cyc = 1; cyc <= WRITE_TIMEOUT; cyc++) begin
            step();
            if (cyc == 1) begin
                apply_write(addr, data);
            end
            if ((inst_rst | inst_readout | inst_start | (|load_cnt_ser))
                || (!want_strobe && cyc == 1)) begin
                break;
            end
            check_state(3'b000, 8'h00, 1'b0);
        end
        if (cyc > WRITE_TIMEOUT) begin
            $display("timed out waiting for the strobe of a write to address %0h", addr);
            timeouts++;
        end else begin
            assert (cyc == 1) else begin
                $display("write strobe came %0d cycles after the frame instead of 1", cyc);
                mismatches++;
            end
            check_state(exp_pulse, exp_load, 1'b0);
            step();
            check_state(3'b000, 8'h00, 1'b0);  // strobes last one cycle
        end
    endtask

    task automatic finish_read(input reg_addr_t addr);
        reg_byte_t exp_byte;
        int        i;
        exp_byte = model_read(addr);
        step();
        check_state(3'b000, 8'h00, 1'b0);
        for (i = 7; i >= 0; i--) begin
            step();
            check_state(3'b000, 8'h00, exp_byte[i]);
        end
        step();
        check_state(3'b000, 8'h00, 1'b0);  // back to idle low
    endtask

    initial begin
        int        n;
        logic      rd;
        reg_addr_t addr;
        reg_byte_t data;
        sclk       = 1'b0;
        rstn       = 1'b0;
        serial_in  = 1'b0;
        pll_locked = 8'h00;
        lfsr       = 32'hfac6;
        mismatches = 0;
        timeouts   = 0;
        exp_cfg    = '0;
        exp_inst   = 8'h00;
        exp_sel    = 3'd7;
        exp_adata  = 8'h00;

        repeat (4) @(posedge sclk);
        #2;
        rstn = 1'b1;
        check_state(3'b000, 8'h00, 1'b0);

        for (n = 0; n < NUM_FRAMES; n++) begin
            pll_locked = reg_byte_t'(rand_bits(8));
            rd         = rand_bits(1);
            addr       = pick_address();
            data       = (addr == ADDR_INSTRUCTION) ? reg_byte_t'(rand_bits(2))
                                                    : reg_byte_t'(rand_bits(8));
            send_frame(rd, addr, data);
            if (rd) begin
                finish_read(addr);
            end else begin
                finish_write(addr, data);
            end
        end

        $display("%0d frames, %0d mismatches, %0d timeouts", NUM_FRAMES, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
source/spi_cfg_pkg.sv
source/spi_frame_rx.sv
source/config_regs.sv
source/reg_readout.sv
source/analog_load_ctrl.sv
source/spi_periph.sv
test/tb_spi_periph.sv

// File: Bender.yml
package:
  name: spi_periph

sources:
  - source/spi_cfg_pkg.sv
  - source/spi_frame_rx.sv
  - source/config_regs.sv
  - source/reg_readout.sv
  - source/analog_load_ctrl.sv
  - source/spi_periph.sv
  - target: test
    files:
      - test/tb_spi_periph.sv
